//--- hw/cpuIsaPkg.sv
package cpuIsaPkg;

	localparam int wordWidth = 16;              // Data and address width
	localparam int irWidth = 10;                // Opcode, X, Y
	localparam int numRegs = 8;                 // R0..R6 plus PC
	localparam int pcReg = 7;                   // R7 is the program counter
	localparam logic [wordWidth-1:0] resetPc = 16'd10; // First program word after data 0..9

	typedef logic [wordWidth-1:0] word_t;
	typedef logic [2:0] regIdx_t;

	typedef enum logic [3:0] {
		opAdd  = 4'b0000,
		opSub  = 4'b0001,
		opOr   = 4'b0010,
		opSlt  = 4'b0011,
		opSll  = 4'b0100,
		opSrl  = 4'b0101,
		opMv   = 4'b0110,
		opMvi  = 4'b0111,
		opLd   = 4'b1000,
		opSd   = 4'b1001,
		opMvnz = 4'b1010
	} opcode_t;

	// Same order as the six ALU opcodes
	typedef enum logic [2:0] {aluAdd, aluSub, aluOr, aluSlt, aluSll, aluSrl} aluOp_t;

	typedef struct packed {
		opcode_t op;                              // IR[9:6]
		regIdx_t rx;                              // Destination, store data for SD
		regIdx_t ry;                              // Source, address for LD/SD
	} instr_t;

endpackage

//--- hw/cpuBusPkg.sv
package cpuBusPkg;

	import cpuIsaPkg::*;

	typedef struct packed {
		word_t addr;                              // Word address
		word_t wdata;                             // Store data, ignored on reads
		logic write;                              // 1 for SD, 0 for fetch/LD/MVI
	} memReq_t;

	typedef enum logic [1:0] {busDin, busG, busReg} busSel_t;

	typedef struct packed {
		busSel_t busSel;                          // Bus source
		regIdx_t srcReg;                          // Register driven on the bus
		logic regWrite;                           // Write bus into dstReg
		regIdx_t dstReg;
		logic aWrite;                             // Load A from bus
		logic gWrite;                             // Load G from ALU
		aluOp_t aluOp;
		logic irWrite;                            // Load IR from DIN
		logic memStart;                           // Memory access in this step
		logic memWrite;                           // Store, alone it stages write data
		logic addrFromPc;                         // Address from PC, else from bus
		logic pcIncr;
		logic done;                               // Last step of the instruction
	} ctrlWord_t;

endpackage

//--- hw/stepCounter.sv
`timescale 1ns/1ps

module stepCounter (
	input  logic       Clock,
	input  logic       rst,
	input  logic       done,                  // Instruction finished
	input  logic       memBusy,               // Memory access still open
	output logic [2:0] step
);

	always_ff @(posedge Clock) begin
		if (rst) begin
			step <= '0;
		end else if (done) begin
			step <= '0;                          // Next instruction starts with fetch
		end else if (!memBusy) begin
			step <= step + 3'd1;
		end
		// Otherwise hold the step while memory waits
	end

endmodule

//--- hw/controlFsm.sv
`timescale 1ns/1ps

module controlFsm import cpuIsaPkg::*, cpuBusPkg::*; (
	input  logic               Clock,
	input  logic               rst,
	input  logic [2:0]         step,
	input  logic [irWidth-1:0] ir,
	input  logic               gZero,         // G holds zero
	output ctrlWord_t          ctrl
);

	instr_t instr;
	regIdx_t loadDst;                          // LD/MVI target kept across the data read

	assign instr = instr_t'(ir);

	always_ff @(posedge Clock) begin
		if (rst) begin
			loadDst <= '0;
		end else if (step == 3'd2 && (instr.op == opLd || instr.op == opMvi)) begin
			loadDst <= instr.rx;
		end
	end

	always_comb begin
		ctrl = '0;
		ctrl.busSel = busReg;
		ctrl.aluOp = aluAdd;
		unique case (step)
			3'd0: begin
				ctrl.memStart = 1'b1;                // Fetch, held until DIN arrives
				ctrl.addrFromPc = 1'b1;
			end
			3'd1: begin
				ctrl.irWrite = 1'b1;
				ctrl.pcIncr = 1'b1;                  // PC steps past the fetched word
			end
			3'd2: begin
				case (instr.op)
					opAdd, opSub, opOr, opSlt, opSll, opSrl: begin
						ctrl.srcReg = instr.rx;          // First operand into A
						ctrl.aWrite = 1'b1;
					end
					opMv: begin
						ctrl.srcReg = instr.ry;
						ctrl.regWrite = 1'b1;
						ctrl.dstReg = instr.rx;
						ctrl.done = 1'b1;
					end
					opMvnz: begin
						ctrl.srcReg = instr.ry;
						ctrl.regWrite = !gZero;          // Copy only after nonzero result
						ctrl.dstReg = instr.rx;
						ctrl.done = 1'b1;
					end
					opMvi: begin
						ctrl.memStart = 1'b1;            // Immediate sits at the current PC
						ctrl.addrFromPc = 1'b1;
					end
					opLd: begin
						ctrl.srcReg = instr.ry;          // Address from Y
						ctrl.memStart = 1'b1;
					end
					opSd: begin
						ctrl.srcReg = instr.rx;          // Stage store data
						ctrl.memWrite = 1'b1;
					end
					default: begin
					end
				endcase
			end
			3'd3: begin
				case (instr.op)
					opAdd, opSub, opOr, opSlt, opSll, opSrl: begin
						ctrl.srcReg = instr.ry;
						ctrl.gWrite = 1'b1;
						// ALU opcodes share their encoding with aluOp_t
						ctrl.aluOp = aluOp_t'(instr.op[2:0]);
					end
					opMvi: begin
						ctrl.busSel = busDin;
						ctrl.regWrite = 1'b1;
						ctrl.dstReg = loadDst;
						ctrl.pcIncr = 1'b1;              // Skip the immediate word
						ctrl.done = 1'b1;
					end
					opLd: begin
						ctrl.busSel = busDin;
						ctrl.regWrite = 1'b1;
						ctrl.dstReg = loadDst;
						ctrl.done = 1'b1;
					end
					opSd: begin
						ctrl.srcReg = instr.ry;          // Address from Y
						ctrl.memStart = 1'b1;
						ctrl.memWrite = 1'b1;
						ctrl.done = 1'b1;                // Store drains during next fetch
					end
					default: begin
					end
				endcase
			end
			3'd4: begin
				case (instr.op)
					opAdd, opSub, opOr, opSlt, opSll, opSrl: begin
						ctrl.busSel = busG;
						ctrl.regWrite = 1'b1;
						ctrl.dstReg = instr.rx;
						ctrl.done = 1'b1;
					end
					default: begin
					end
				endcase
			end
			default: begin
			end
		endcase
	end

endmodule

//--- hw/registerFile.sv
`timescale 1ns/1ps

module registerFile import cpuIsaPkg::*, cpuBusPkg::*; (
	input  logic      Clock,
	input  logic      rst,
	input  ctrlWord_t ctrl,
	input  word_t     bus,
	output word_t     rdata,                  // Register selected by srcReg
	output word_t     pc
);

	word_t regs [numRegs-1];                   // R0..R6, R7 lives in pc
	logic readPc;
	logic writeGpr;

	assign readPc = (ctrl.srcReg == regIdx_t'(pcReg));
	assign writeGpr = ctrl.regWrite && (ctrl.dstReg != regIdx_t'(pcReg)); // R7 not writable

	always_ff @(posedge Clock) begin
		if (writeGpr) begin
			regs[ctrl.dstReg] <= bus;
		end
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			pc <= resetPc;
		end else if (ctrl.pcIncr) begin
			pc <= pc + word_t'(1);
		end
	end

	always_comb begin
		if (readPc) begin
			rdata = pc;
		end else begin
			rdata = regs[ctrl.srcReg];
		end
	end

endmodule

//--- hw/aluDatapath.sv
`timescale 1ns/1ps

module aluDatapath import cpuIsaPkg::*, cpuBusPkg::*; (
	input  logic               Clock,
	input  logic               rst,
	input  ctrlWord_t          ctrl,
	input  word_t              rdata,
	input  word_t              din,
	output word_t              bus,
	output logic [irWidth-1:0] ir,
	output logic               gZero
);

	word_t aReg;                               // First ALU operand
	word_t gReg;                               // Last ALU result
	word_t aluResult;

	always_comb begin
		case (ctrl.busSel)
			busDin:  bus = din;
			busG:    bus = gReg;
			default: bus = rdata;
		endcase
	end

	always_comb begin
		case (ctrl.aluOp)
			aluAdd:  aluResult = aReg + bus;
			aluSub:  aluResult = aReg - bus;
			aluOr:   aluResult = aReg | bus;
			aluSlt:  aluResult = (aReg < bus) ? word_t'(1) : '0; // Unsigned compare
			aluSll:  aluResult = aReg << bus[3:0]; // Shift amount 0..15
			aluSrl:  aluResult = aReg >> bus[3:0];
			default: aluResult = '0;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (ctrl.aWrite) begin
			aReg <= bus;
		end
		if (ctrl.gWrite) begin
			gReg <= aluResult;
		end
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			ir <= '0;
		end else if (ctrl.irWrite) begin
			ir <= din[irWidth-1:0];                 // Upper bits of the word unused
		end
	end

	assign gZero = (gReg == '0);

endmodule

//--- hw/memPort.sv
`timescale 1ns/1ps

module memPort import cpuIsaPkg::*, cpuBusPkg::*; (
	input  logic      Clock,
	input  logic      rst,
	input  ctrlWord_t ctrl,
	input  word_t     bus,
	input  word_t     pc,
	output memReq_t   memReq,
	output logic      memReqValid,
	input  logic      memReqReady,
	input  word_t     memRsp,
	input  logic      memRspValid,
	output word_t     din,
	output logic      memBusy
);

	logic waitRsp;                             // Read accepted, data not back yet
	logic launch;
	logic accept;
	logic rspDone;

	assign launch = ctrl.memStart && !memReqValid && !waitRsp; // Port free, new access
	assign accept = memReqValid && memReqReady;
	assign rspDone = waitRsp && memRspValid;
	// Reads hold the step until data lands; a store is posted and only its launch is free
	assign memBusy = ctrl.memStart && !(launch && ctrl.memWrite) && !rspDone;

	always_ff @(posedge Clock) begin
		if (rst) begin
			memReqValid <= 1'b0;
			waitRsp <= 1'b0;
		end else begin
			if (launch) begin
				memReqValid <= 1'b1;
			end else if (accept) begin
				memReqValid <= 1'b0;
			end
			if (accept && !memReq.write) begin
				waitRsp <= 1'b1;
			end else if (rspDone) begin
				waitRsp <= 1'b0;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (launch) begin
			memReq.addr <= ctrl.addrFromPc ? pc : bus;
			memReq.write <= ctrl.memWrite;
		end else if (ctrl.memWrite && !ctrl.memStart && !memReqValid) begin
			memReq.wdata <= bus;                   // SD data, one step before the address
		end
		if (rspDone) begin
			din <= memRsp;
		end
	end

endmodule

//--- hw/simpleProc.sv
`timescale 1ns/1ps

module simpleProc import cpuIsaPkg::*, cpuBusPkg::*; (
	input  logic    Clock,
	input  logic    rst,
	output memReq_t memReq,
	output logic    memReqValid,
	input  logic    memReqReady,
	input  word_t   memRsp,
	input  logic    memRspValid,
	output logic    done                      // One pulse per instruction
);

	ctrlWord_t ctrl;
	logic [2:0] step;
	logic [irWidth-1:0] ir;
	logic gZero;
	logic memBusy;
	word_t bus;
	word_t rdata;
	word_t pc;
	word_t din;

	assign done = ctrl.done;

	stepCounter i_stepCounter (.Clock, .rst, .done(ctrl.done), .memBusy, .step);

	controlFsm i_controlFsm (.Clock, .rst, .step, .ir, .gZero, .ctrl);

	registerFile i_registerFile (.Clock, .rst, .ctrl, .bus, .rdata, .pc);

	aluDatapath i_aluDatapath (.Clock, .rst, .ctrl, .rdata, .din, .bus, .ir, .gZero);

	memPort i_memPort (
		.Clock,
		.rst,
		.ctrl,
		.bus,
		.pc,
		.memReq,
		.memReqValid,
		.memReqReady,
		.memRsp,
		.memRspValid,
		.din,
		.memBusy
	);

endmodule

//--- sim/simpleProc_sva.sv
`timescale 1ns/1ps

module simpleProc_sva import cpuBusPkg::*; (
	input logic    Clock,
	input logic    rst,
	input memReq_t memReq,
	input logic    memReqValid,
	input logic    memReqReady,
	input logic    done
);

	int failCount = 0;                         // Failed assertion count

	// Request held under back-pressure
	property reqHeld;
		@(posedge Clock) disable iff (rst)
		memReqValid && !memReqReady |=> memReqValid && $stable(memReq);
	endproperty

	assert property (reqHeld) else begin
		$error("Memory request dropped or changed before ready");
		failCount++;
	end

	assert property (@(posedge Clock) rst |=> !memReqValid) else begin
		$error("Memory request valid while in reset");
		failCount++;
	end

	assert property (@(posedge Clock) disable iff (rst) done |=> !done) else begin
		$error("Done high for two cycles in a row");
		failCount++;
	end

endmodule

bind simpleProc simpleProc_sva i_simpleProc_sva (.*);

//--- sim/simpleProcTb.sv
`timescale 1ns/1ps

module simpleProcTb import cpuIsaPkg::*, cpuBusPkg::*; ();

	localparam int progLen = 48;               // Program words from resetPc
	localparam int numInstr = 43;              // Five MVIs take two words each
	localparam int numStores = 11;
	localparam int maxInstrCycles = 24;        // Two reads with full stall and delay, plus drain
	localparam int cycleLimit = numInstr * maxInstrCycles + 100;

	typedef struct packed {
		word_t addr;
		word_t data;
	} store_t;

	logic Clock;
	logic rst;
	memReq_t memReq;
	logic memReqValid;
	logic memReqReady = 1'b0;
	word_t memRsp = '0;
	logic memRspValid = 1'b0;
	logic done;

	word_t mem [256];                          // Data 0..9, program from 10, stores from 0x40
	word_t prog [progLen];
	store_t expStores [numStores];
	int storeIdx = 0;
	int doneCount = 0;
	int cycles = 0;
	int errors = 0;
	int lowLeft;                               // Remaining cycles of ready low
	int rspWait;
	logic rspPending;
	word_t rspAddr;
	word_t expPc;                              // Next expected fetch address
	logic fetchNext;                           // Next read is an instruction fetch

	simpleProc i_simpleProc (
		.Clock,
		.rst,
		.memReq,
		.memReqValid,
		.memReqReady,
		.memRsp,
		.memRspValid,
		.done
	);

	always #10 Clock = ~Clock;

	// Opcode, X, Y packed into the low 10 bits
	function automatic word_t encode(opcode_t op, int x, int y);
		return word_t'({op, 3'(x), 3'(y)});
	endfunction

	task automatic checkStore(input word_t addr, input word_t data);
		if (storeIdx >= numStores) begin
			$display("Store of %h to address %h was not expected", data, addr);
			errors++;
		end else begin
			assert (addr == expStores[storeIdx].addr) else begin
				$display("[FAIL] store %0d address: expected %h, actual %h",
					storeIdx, expStores[storeIdx].addr, addr);
				errors++;
			end
			assert (data == expStores[storeIdx].data) else begin
				$display("[FAIL] store %0d data: expected %h, actual %h",
					storeIdx, expStores[storeIdx].data, data);
				errors++;
			end
		end
	endtask

	always @(posedge Clock) begin
		if (rst) begin
			memReqReady <= 1'b0;
			memRspValid <= 1'b0;
			rspPending <= 1'b0;
			lowLeft <= 0;
			fetchNext <= 1'b1;                     // First read after reset is a fetch
			expPc <= resetPc;
		end else begin
			cycles <= cycles + 1;
			memRspValid <= 1'b0;                   // Single-cycle response pulse
			if (lowLeft != 0) begin
				lowLeft <= lowLeft - 1;
				memReqReady <= (lowLeft == 1);
			end else if ($urandom % 4 == 0) begin
				lowLeft <= $urandom_range(3, 1);     // Back-pressure of 1..3 cycles
				memReqReady <= 1'b0;
			end else begin
				memReqReady <= 1'b1;
			end
			if (rspPending) begin
				if (rspWait == 0) begin
					memRsp <= mem[rspAddr[7:0]];
					memRspValid <= 1'b1;
					rspPending <= 1'b0;
				end else begin
					rspWait <= rspWait - 1;
				end
			end
			if (memReqValid && memReqReady) begin
				if (memReq.write) begin
					checkStore(memReq.addr, memReq.wdata);
					storeIdx <= storeIdx + 1;
					mem[memReq.addr[7:0]] <= memReq.wdata;
				end else begin
					rspPending <= 1'b1;
					rspWait <= $urandom % 4;            // Extra delay 0..3 after the first cycle
					rspAddr <= memReq.addr;
					if (fetchNext) begin
						assert (memReq.addr == expPc) else begin
							$display("[FAIL] fetch address: expected %h, actual %h",
								expPc, memReq.addr);
							errors++;
						end
						// MVI skips its immediate word
						expPc <= expPc + ((mem[expPc[7:0]][9:6] == opMvi) ? 16'd2 : 16'd1);
						fetchNext <= 1'b0;
					end
				end
			end
			if (done) begin
				doneCount <= doneCount + 1;
				fetchNext <= 1'b1;
			end
		end
	end

	initial begin
		void'($urandom(32'h488c_ac7a));
		Clock = 1'b0;
		rst = 1'b1;
		// Four MVIs, then ALU ops each stored at the next address in R6
		prog = '{
			encode(opMvi, 6, 0), 16'h0040, encode(opMvi, 0, 0), 16'h1234,
			encode(opMvi, 1, 0), 16'h0F0F, encode(opMvi, 5, 0), 16'h0001,
			encode(opSd, 0, 6), encode(opAdd, 6, 5), encode(opSd, 1, 6),
			encode(opMv, 2, 0), encode(opAdd, 2, 1), encode(opAdd, 6, 5), encode(opSd, 2, 6),
			encode(opMv, 2, 0), encode(opSub, 2, 1), encode(opAdd, 6, 5), encode(opSd, 2, 6),
			encode(opMv, 2, 0), encode(opOr, 2, 1), encode(opAdd, 6, 5), encode(opSd, 2, 6),
			encode(opMv, 2, 1), encode(opSlt, 2, 0), encode(opAdd, 6, 5), encode(opSd, 2, 6),
			encode(opMv, 2, 0), encode(opSll, 2, 5), encode(opAdd, 6, 5), encode(opSd, 2, 6),
			encode(opMv, 2, 1), encode(opSrl, 2, 0), encode(opAdd, 6, 5), encode(opSd, 2, 6),
			encode(opMvnz, 3, 0), encode(opAdd, 6, 5), encode(opSd, 3, 6), encode(opAdd, 6, 5),
			encode(opMv, 2, 0), encode(opSub, 2, 0), encode(opMvnz, 3, 1), encode(opSd, 3, 6),
			encode(opMvi, 4, 0), 16'h0005, encode(opLd, 3, 4), encode(opAdd, 6, 5),
			encode(opSd, 3, 6)
		};
		// MVI, ADD, SUB, OR, SLT, SLL, SRL by 4, MVNZ taken, MVNZ skipped, LD
		expStores = '{
			{16'h0040, 16'h1234}, {16'h0041, 16'h0F0F}, {16'h0042, 16'h2143},
			{16'h0043, 16'h0325}, {16'h0044, 16'h1F3F}, {16'h0045, 16'h0001},
			{16'h0046, 16'h2468}, {16'h0047, 16'h00F0}, {16'h0048, 16'h1234},
			{16'h0049, 16'h1234}, {16'h004A, 16'h1005}
		};
		for (int i = 0; i < 256; i++) begin
			mem[i] = (i < 10) ? word_t'(16'h1000 + i) : '0;
		end
		for (int i = 0; i < progLen; i++) begin
			mem[int'(resetPc) + i] = prog[i];
		end
		repeat (3) @(posedge Clock);
		rst <= 1'b0;
		while ((storeIdx < numStores || doneCount < numInstr) && cycles < cycleLimit) begin
			@(posedge Clock);
		end
		if (cycles >= cycleLimit) begin
			$display("Timeout after %0d cycles with %0d of %0d stores seen",
				cycles, storeIdx, numStores);
			errors++;
		end
		assert (doneCount == numInstr) else begin
			$display("[FAIL] done pulses: expected %0d, actual %0d", numInstr, doneCount);
			errors++;
		end
		errors += i_simpleProc.i_simpleProc_sva.failCount; // Bound assertion failures
		$display("Errors: %0d, assertion failures: %0d, stores: %0d of %0d, done pulses: %0d of %0d, cycles: %0d",
			errors, i_simpleProc.i_simpleProc_sva.failCount, storeIdx, numStores,
			doneCount, numInstr, cycles);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- vlog.f
hw/cpuIsaPkg.sv
hw/cpuBusPkg.sv
hw/stepCounter.sv
hw/controlFsm.sv
hw/registerFile.sv
hw/aluDatapath.sv
hw/memPort.sv
hw/simpleProc.sv
sim/simpleProc_sva.sv
sim/simpleProcTb.sv

//--- Bender.yml
package:
  name: simple_proc

sources:
  - files:
      - hw/cpuIsaPkg.sv
      - hw/cpuBusPkg.sv
      - hw/stepCounter.sv
      - hw/controlFsm.sv
      - hw/registerFile.sv
      - hw/aluDatapath.sv
      - hw/memPort.sv
      - hw/simpleProc.sv
  - target: simulation
    files:
      - sim/simpleProc_sva.sv
      - sim/simpleProcTb.sv
